//--- compile.f
hdl/mem_pkg.sv
hdl/load_store_unit.sv
hdl/bank_decoder.sv
hdl/data_bank.sv
hdl/response_merger.sv
hdl/mem_stage_top.sv
tb/tb_mem_stage.sv

//--- hdl/bank_decoder.sv
// AXI4-Lite address decoder: one request slot per direction, routed to one interleaved bank
module bank_decoder (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [31:0]                         awaddr,
    input  logic                                wvalid,
    output logic                                wready,
    input  logic [31:0]                         wdata,
    input  logic [3:0]                          wstrb,
    input  logic                                arvalid,
    output logic                                arready,
    input  logic [31:0]                         araddr,
    output logic [mem_pkg::num_banks-1:0]       bank_awvalid,
    input  logic [mem_pkg::num_banks-1:0]       bank_awready,
    output logic [mem_pkg::row_bits-1:0]        bank_row_w [mem_pkg::num_banks],
    output logic [mem_pkg::num_banks-1:0]       bank_wvalid,
    input  logic [mem_pkg::num_banks-1:0]       bank_wready,
    output logic [31:0]                         bank_wdata [mem_pkg::num_banks],
    output logic [3:0]                          bank_wstrb [mem_pkg::num_banks],
    output logic [mem_pkg::num_banks-1:0]       bank_arvalid,
    input  logic [mem_pkg::num_banks-1:0]       bank_arready,
    output logic [mem_pkg::row_bits-1:0]        bank_row_r [mem_pkg::num_banks],
    output logic                                wr_pending,
    output logic [mem_pkg::bank_sel_bits-1:0]   wr_bank,
    output logic                                wr_err,
    output logic                                rd_pending,
    output logic [mem_pkg::bank_sel_bits-1:0]   rd_bank,
    output logic                                rd_err,
    input  logic                                wr_done,
    input  logic                                rd_done
);

    logic                         wr_full;     // write request still to be handed to a bank
    logic                         rd_full;
    logic [mem_pkg::row_bits-1:0] row_w_q;
    logic [mem_pkg::row_bits-1:0] row_r_q;
    logic [31:0]                  wdata_q;
    logic [3:0]                   wstrb_q;
    logic                         wr_accept;
    logic                         rd_accept;
    logic                         aw_out;
    logic                         ar_out;

    assign awready   = wvalid && !wr_pending;
    assign wready    = awvalid && !wr_pending;
    assign arready   = !rd_pending;
    assign wr_accept = awvalid && wvalid && !wr_pending;
    assign rd_accept = arvalid && !rd_pending;
    assign aw_out    = awaddr >= mem_pkg::mem_bytes;
    assign ar_out    = araddr >= mem_pkg::mem_bytes;

    always_comb begin
        for (int i = 0; i < mem_pkg::num_banks; i++) begin
            bank_awvalid[i] = wr_full && (int'(wr_bank) == i);
            bank_wvalid[i]  = wr_full && (int'(wr_bank) == i);
            bank_arvalid[i] = rd_full && (int'(rd_bank) == i);
            bank_row_w[i]   = row_w_q;   // payload broadcast, valid picks the bank
            bank_row_r[i]   = row_r_q;
            bank_wdata[i]   = wdata_q;
            bank_wstrb[i]   = wstrb_q;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_pending <= 1'b0;
            wr_full    <= 1'b0;
            rd_pending <= 1'b0;
            rd_full    <= 1'b0;
        end else begin
            if (wr_accept) begin
                wr_pending <= 1'b1;
                wr_full    <= !aw_out;   // decode error never reaches a bank
            end else begin
                if (wr_full && bank_awready[wr_bank] && bank_wready[wr_bank]) wr_full <= 1'b0;
                if (wr_done) wr_pending <= 1'b0;
            end
            if (rd_accept) begin
                rd_pending <= 1'b1;
                rd_full    <= !ar_out;
            end else begin
                if (rd_full && bank_arready[rd_bank]) rd_full <= 1'b0;
                if (rd_done) rd_pending <= 1'b0;
            end
        end
    end

    // word interleave: low word bits pick the bank, the rest the row
    always_ff @(posedge clock) begin
        if (wr_accept) begin
            wr_bank <= awaddr[2 +: mem_pkg::bank_sel_bits];
            row_w_q <= awaddr[2 + mem_pkg::bank_sel_bits +: mem_pkg::row_bits];
            wr_err  <= aw_out;
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (rd_accept) begin
            rd_bank <= araddr[2 +: mem_pkg::bank_sel_bits];
            row_r_q <= araddr[2 + mem_pkg::bank_sel_bits +: mem_pkg::row_bits];
            rd_err  <= ar_out;
        end
    end

endmodule

//--- hdl/data_bank.sv
// one AXI4-Lite memory bank holding a word-interleaved slice, byte-strobed writes
module data_bank (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [mem_pkg::row_bits-1:0] row_w,
    input  logic                         wvalid,
    output logic                         wready,
    input  logic [31:0]                  wdata,
    input  logic [3:0]                   wstrb,
    output logic                         bvalid,
    input  logic                         bready,
    output logic [1:0]                   bresp,
    input  logic                         arvalid,
    output logic                         arready,
    input  logic [mem_pkg::row_bits-1:0] row_r,
    output logic                         rvalid,
    input  logic                         rready,
    output logic [31:0]                  rdata,
    output logic [1:0]                   rresp
);

    logic [31:0] mem [mem_pkg::bank_words];
    logic        wr_fire;
    logic        rd_fire;

    assign awready = wvalid && !bvalid;   // AW and W only together
    assign wready  = awvalid && !bvalid;
    assign arready = !rvalid;
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign rd_fire = arvalid && !rvalid;
    assign bresp   = mem_pkg::resp_okay;
    assign rresp   = mem_pkg::resp_okay;

    always_ff @(posedge clock) begin
        if (reset) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_fire) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            if (rd_fire) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_fire) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) mem[row_w][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
        if (rd_fire) rdata <= mem[row_r];
    end

endmodule

//--- hdl/load_store_unit.sv
// load/store unit of the memory stage: takes execute ops, runs AXI4-Lite accesses, emits writeback
module load_store_unit (
    input  logic        clock,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic        op_load,
    input  logic        op_store,
    input  logic [2:0]  funct3,
    input  logic [31:0] addr,
    input  logic [31:0] store_data,
    input  logic [4:0]  rd,
    input  logic        reg_wen,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] out_data,
    output logic [4:0]  out_rd,
    output logic        out_reg_wen,
    output logic        out_fault,
    output logic        awvalid,
    input  logic        awready,
    output logic [31:0] awaddr,
    output logic        wvalid,
    input  logic        wready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    input  logic        bvalid,
    output logic        bready,
    input  logic [1:0]  bresp,
    output logic        arvalid,
    input  logic        arready,
    output logic [31:0] araddr,
    input  logic        rvalid,
    output logic        rready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp
);

    logic        busy;          // memory op in flight or its result not yet taken
    logic        load_q;
    logic        store_q;
    logic [2:0]  funct3_q;
    logic [31:0] addr_q;
    logic        accept;
    logic        is_mem;
    logic        is_half;
    logic        is_word;
    logic        misaligned;
    logic [3:0]  strb_base;
    logic [31:0] lane_data;
    logic [31:0] load_value;
    logic        b_fire;
    logic        r_fire;

    function automatic logic resp_fault(input logic [1:0] resp);
        return (resp == mem_pkg::resp_slverr) || (resp == mem_pkg::resp_decerr);
    endfunction

    assign in_ready   = !busy && (!out_valid || out_ready);
    assign accept     = in_valid && in_ready;
    assign is_mem     = op_load || op_store;
    assign is_half    = (funct3 == mem_pkg::f3_half) || (funct3 == mem_pkg::f3_half_u);
    assign is_word    = funct3 == mem_pkg::f3_word;
    assign misaligned = (is_half && addr[1:0] == 2'd3) || (is_word && addr[1:0] != 2'd0);

    assign awaddr = addr_q;
    assign araddr = addr_q;
    assign bready = busy && store_q && !out_valid;
    assign rready = busy && load_q && !out_valid;
    assign b_fire = bvalid && bready;
    assign r_fire = rvalid && rready;

    always_comb begin
        case (funct3)
            mem_pkg::f3_byte: strb_base = 4'b0001;
            mem_pkg::f3_half: strb_base = 4'b0011;
            default:          strb_base = 4'b1111;
        endcase
    end

    // move the addressed lane down to bit 0, then extend
    always_comb begin
        lane_data = rdata >> {addr_q[1:0], 3'b000};
        case (funct3_q)
            mem_pkg::f3_byte:   load_value = {{24{lane_data[7]}}, lane_data[7:0]};
            mem_pkg::f3_half:   load_value = {{16{lane_data[15]}}, lane_data[15:0]};
            mem_pkg::f3_byte_u: load_value = {24'd0, lane_data[7:0]};
            mem_pkg::f3_half_u: load_value = {16'd0, lane_data[15:0]};
            default:            load_value = lane_data;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy      <= 1'b0;
            out_valid <= 1'b0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            arvalid   <= 1'b0;
        end else begin
            if (awvalid && awready) awvalid <= 1'b0;
            if (wvalid && wready) wvalid <= 1'b0;
            if (arvalid && arready) arvalid <= 1'b0;
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
                busy      <= 1'b0;
            end
            if (r_fire || b_fire) out_valid <= 1'b1;
            if (accept) begin
                if (is_mem && !misaligned) begin
                    busy    <= 1'b1;
                    arvalid <= op_load;
                    awvalid <= op_store;
                    wvalid  <= op_store;   // AW and W go out together
                end else begin
                    out_valid <= 1'b1;     // pass-through or fault, no bus traffic
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            load_q      <= op_load;
            store_q     <= op_store;
            funct3_q    <= funct3;
            addr_q      <= addr;
            wdata       <= store_data << {addr[1:0], 3'b000};
            wstrb       <= strb_base << addr[1:0];
            out_data    <= addr;
            out_rd      <= rd;
            out_reg_wen <= reg_wen && !op_store;   // stores never write rd
            out_fault   <= is_mem && misaligned;
        end
        if (r_fire) begin
            out_data  <= load_value;
            out_fault <= resp_fault(rresp);
        end
        if (b_fire) out_fault <= resp_fault(bresp);
    end

endmodule

//--- hdl/mem_pkg.sv
// shared sizes and encodings for the memory stage, referenced by scoped name from every module
package mem_pkg;

    localparam int num_banks     = 4;
    localparam int bank_words    = 64;     // words per bank
    localparam int bank_sel_bits = 2;
    localparam int row_bits      = 6;
    localparam int mem_bytes     = 1024;   // decoded range, everything above is DECERR

    // funct3 of RV32 loads and stores
    localparam logic [2:0] f3_byte   = 3'd0;
    localparam logic [2:0] f3_half   = 3'd1;
    localparam logic [2:0] f3_word   = 3'd2;
    localparam logic [2:0] f3_byte_u = 3'd4;
    localparam logic [2:0] f3_half_u = 3'd5;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_slverr = 2'd2;
    localparam logic [1:0] resp_decerr = 2'd3;

endpackage

//--- hdl/mem_stage_top.sv
// memory stage top: load/store unit on an interleaved AXI4-Lite data memory
module mem_stage_top (
    input  logic        clock,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic        op_load,
    input  logic        op_store,
    input  logic [2:0]  funct3,
    input  logic [31:0] addr,
    input  logic [31:0] store_data,
    input  logic [4:0]  rd,
    input  logic        reg_wen,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] out_data,
    output logic [4:0]  out_rd,
    output logic        out_reg_wen,
    output logic        out_fault
);

    logic                              awvalid, awready, wvalid, wready, arvalid, arready;
    logic                              bvalid, bready, rvalid, rready;
    logic [31:0]                       awaddr, araddr, wdata, rdata;
    logic [3:0]                        wstrb;
    logic [1:0]                        bresp, rresp;
    logic                              wr_pending, wr_err, rd_pending, rd_err;
    logic                              wr_done, rd_done;
    logic [mem_pkg::bank_sel_bits-1:0] wr_bank, rd_bank;
    logic [mem_pkg::num_banks-1:0]     bank_awvalid, bank_awready, bank_wvalid, bank_wready;
    logic [mem_pkg::num_banks-1:0]     bank_arvalid, bank_arready;
    logic [mem_pkg::num_banks-1:0]     bank_bvalid, bank_bready, bank_rvalid, bank_rready;
    logic [mem_pkg::row_bits-1:0]      bank_row_w [mem_pkg::num_banks];
    logic [mem_pkg::row_bits-1:0]      bank_row_r [mem_pkg::num_banks];
    logic [31:0]                       bank_wdata [mem_pkg::num_banks];
    logic [31:0]                       bank_rdata [mem_pkg::num_banks];
    logic [3:0]                        bank_wstrb [mem_pkg::num_banks];
    logic [1:0]                        bank_bresp [mem_pkg::num_banks];
    logic [1:0]                        bank_rresp [mem_pkg::num_banks];

    load_store_unit lsu (.*);

    bank_decoder decoder (.*);

    for (genvar i = 0; i < mem_pkg::num_banks; i++) begin : g_bank
        data_bank bank (
            .clock   (clock),
            .reset   (reset),
            .awvalid (bank_awvalid[i]),
            .awready (bank_awready[i]),
            .row_w   (bank_row_w[i]),
            .wvalid  (bank_wvalid[i]),
            .wready  (bank_wready[i]),
            .wdata   (bank_wdata[i]),
            .wstrb   (bank_wstrb[i]),
            .bvalid  (bank_bvalid[i]),
            .bready  (bank_bready[i]),
            .bresp   (bank_bresp[i]),
            .arvalid (bank_arvalid[i]),
            .arready (bank_arready[i]),
            .row_r   (bank_row_r[i]),
            .rvalid  (bank_rvalid[i]),
            .rready  (bank_rready[i]),
            .rdata   (bank_rdata[i]),
            .rresp   (bank_rresp[i])
        );
    end

    response_merger merger (.*);

endmodule

//--- hdl/response_merger.sv
// merges bank B/R responses back to the single master, DECERR for unmapped addresses
module response_merger (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              wr_pending,
    input  logic [mem_pkg::bank_sel_bits-1:0] wr_bank,
    input  logic                              wr_err,
    input  logic                              rd_pending,
    input  logic [mem_pkg::bank_sel_bits-1:0] rd_bank,
    input  logic                              rd_err,
    input  logic [mem_pkg::num_banks-1:0]     bank_bvalid,
    output logic [mem_pkg::num_banks-1:0]     bank_bready,
    input  logic [1:0]                        bank_bresp [mem_pkg::num_banks],
    input  logic [mem_pkg::num_banks-1:0]     bank_rvalid,
    output logic [mem_pkg::num_banks-1:0]     bank_rready,
    input  logic [31:0]                       bank_rdata [mem_pkg::num_banks],
    input  logic [1:0]                        bank_rresp [mem_pkg::num_banks],
    output logic                              bvalid,
    input  logic                              bready,
    output logic [1:0]                        bresp,
    output logic                              rvalid,
    input  logic                              rready,
    output logic [31:0]                       rdata,
    output logic [1:0]                        rresp,
    output logic                              wr_done,
    output logic                              rd_done
);

    logic b_take;
    logic r_take;

    assign b_take  = wr_pending && !bvalid && (wr_err || bank_bvalid[wr_bank]);
    assign r_take  = rd_pending && !rvalid && (rd_err || bank_rvalid[rd_bank]);
    assign wr_done = bvalid && bready;
    assign rd_done = rvalid && rready;

    always_comb begin
        for (int i = 0; i < mem_pkg::num_banks; i++) begin
            bank_bready[i] = wr_pending && !wr_err && !bvalid && (int'(wr_bank) == i);
            bank_rready[i] = rd_pending && !rd_err && !rvalid && (int'(rd_bank) == i);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_done) bvalid <= 1'b0;
            else if (b_take) bvalid <= 1'b1;
            if (rd_done) rvalid <= 1'b0;
            else if (r_take) rvalid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (b_take) bresp <= wr_err ? mem_pkg::resp_decerr : bank_bresp[wr_bank];
        if (r_take) begin
            rresp <= rd_err ? mem_pkg::resp_decerr : bank_rresp[rd_bank];
            rdata <= rd_err ? 32'd0 : bank_rdata[rd_bank];
        end
    end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f compile.f --top-module tb_mem_stage \
    -Mdir obj_dir -o sim_mem_stage || exit 1
./obj_dir/sim_mem_stage > sim.log 2>&1 || echo "simulator exited with a failing status" >> sim.log
cat sim.log
grep -q '\*\*\* TEST FAILED \*\*\*' sim.log && exit 1
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log || exit 1
exit 0

//--- tb/tb_mem_stage.sv
// simulation top that runs directed tests of mem_stage_top against a reference memory
module tb_mem_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit = 200;   // cycles per handshake

    logic        clock = 1'b0;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    logic        op_load;
    logic        op_store;
    logic [2:0]  funct3;
    logic [31:0] addr;
    logic [31:0] store_data;
    logic [4:0]  rd;
    logic        reg_wen;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] out_data;
    logic [4:0]  out_rd;
    logic        out_reg_wen;
    logic        out_fault;
    logic [31:0] ref_mem [256];        // expected contents per word
    logic [31:0] res_data;
    logic [4:0]  res_rd;
    logic        res_wen;
    logic        res_fault;
    int          seed = 32'h1512_8c20;

    mem_stage_top UUT (.*);

    always #20 clock = ~clock;

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_rd(input string name, input logic [4:0] expected,
                            input logic [4:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            stop_run();
        end
    endtask

    function automatic int access_bytes(input logic [2:0] f3);
        case (f3)
            mem_pkg::f3_byte, mem_pkg::f3_byte_u: return 1;
            mem_pkg::f3_half, mem_pkg::f3_half_u: return 2;
            default:                              return 4;
        endcase
    endfunction

    function automatic void store_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] d);
        int          off;
        int          k;
        logic [31:0] mask;
        logic [31:0] lane;
        off = int'(a[1:0]);
        for (k = 0; k < access_bytes(f3); k++) begin   // byte k of the data to byte off+k
            mask = 32'hff << (8 * (off + k));
            lane = ((d >> (8 * k)) & 32'hff) << (8 * (off + k));
            ref_mem[a[9:2]] = (ref_mem[a[9:2]] & ~mask) | lane;
        end
    endfunction

    function automatic logic [31:0] expect_load(input logic [2:0] f3, input logic [31:0] a);
        int          nbytes;
        logic [31:0] keep;
        logic [31:0] value;
        logic        sign;
        nbytes = access_bytes(f3);
        keep   = (nbytes == 4) ? 32'hffff_ffff : ((32'd1 << (8 * nbytes)) - 32'd1);
        value  = (ref_mem[a[9:2]] >> (8 * int'(a[1:0]))) & keep;
        if (nbytes == 1) sign = value[7];
        else if (nbytes == 2) sign = value[15];
        else sign = 1'b0;
        if (f3 != mem_pkg::f3_byte_u && f3 != mem_pkg::f3_half_u && sign) value = value | ~keep;
        return value;
    endfunction

    // starts after a rising edge and returns on the accepting edge
    task automatic issue(input logic ld, input logic st, input logic [2:0] f3,
                         input logic [31:0] a, input logic [31:0] d, input logic [4:0] r,
                         input logic we);
        int n;
        n = 0;
        in_valid   <= 1'b1;
        op_load    <= ld;
        op_store   <= st;
        funct3     <= f3;
        addr       <= a;
        store_data <= d;
        rd         <= r;
        reg_wen    <= we;
        @(negedge clock);
        while (!in_ready) begin
            n++;
            if (n > wait_limit) begin
                $display("timeout: in_ready stayed low, the operation was never accepted");
                stop_run();
            end
            @(negedge clock);
        end
        @(posedge clock);
        in_valid <= 1'b0;
    endtask

    // with hold > 0 out_ready is already low and stays low for hold more cycles
    task automatic collect(input string name, input int hold);
        int n;
        int i;
        n = 0;
        @(negedge clock);
        while (!out_valid) begin
            n++;
            if (n > wait_limit) begin
                $display("timeout: out_valid never rose in test %s", name);
                stop_run();
            end
            @(negedge clock);
        end
        res_data  = out_data;
        res_rd    = out_rd;
        res_wen   = out_reg_wen;
        res_fault = out_fault;
        for (i = 0; i < hold; i++) begin
            @(negedge clock);
            check_flag({name, " held out_valid"}, 1'b1, out_valid);
            check_data({name, " held out_data"}, res_data, out_data);
            check_rd({name, " held out_rd"}, res_rd, out_rd);
            check_flag({name, " held out_fault"}, res_fault, out_fault);
            check_flag({name, " held in_ready"}, 1'b0, in_ready);
        end
        if (hold > 0) begin
            @(posedge clock);
            out_ready <= 1'b1;
        end
        @(posedge clock);
    endtask

    task automatic do_store(input string name, input logic [2:0] f3, input logic [31:0] a,
                            input logic [31:0] d);
        issue(1'b0, 1'b1, f3, a, d, a[6:2], 1'b1);
        collect(name, 0);
        check_flag({name, " fault"}, 1'b0, res_fault);
        check_flag({name, " reg_wen"}, 1'b0, res_wen);
        store_ref(f3, a, d);
    endtask

    task automatic do_load(input string name, input logic [2:0] f3, input logic [31:0] a,
                           input int hold);
        issue(1'b1, 1'b0, f3, a, 32'h5a5a_a5a5, a[6:2] ^ 5'h0a, 1'b1);
        collect(name, hold);
        check_data(name, expect_load(f3, a), res_data);
        check_rd({name, " rd"}, a[6:2] ^ 5'h0a, res_rd);
        check_flag({name, " fault"}, 1'b0, res_fault);
        check_flag({name, " reg_wen"}, 1'b1, res_wen);
    endtask

    task automatic expect_fault(input string name, input logic ld, input logic st,
                                input logic [2:0] f3, input logic [31:0] a);
        issue(ld, st, f3, a, 32'h1234_5678, 5'd7, 1'b1);
        collect(name, 0);
        check_flag(name, 1'b1, res_fault);
    endtask

    task automatic test_word_round_trip();
        int          i;
        logic [31:0] a;
        for (i = 0; i < 256; i++) begin   // fills the whole range across all four banks
            a = 32'(i) << 2;
            do_store("word round trip", mem_pkg::f3_word, a, {a[15:0] ^ 16'h8c3b, ~a[15:0]});
        end
        for (i = 0; i < 256; i++) begin
            a = 32'(i) << 2;
            do_load("word round trip", mem_pkg::f3_word, a, 0);
        end
    endtask

    task automatic test_sub_word();
        int          w;
        int          off;
        logic [31:0] a;
        for (w = 0; w < 4; w++) begin
            for (off = 0; off < 4; off++) begin
                a = 32'h0000_0100 + 32'(4 * w + off);
                do_store("byte store", mem_pkg::f3_byte, a,
                         32'hffff_ff80 ^ 32'(17 * (4 * w + off)));
                do_load("lb", mem_pkg::f3_byte, a, 0);
                do_load("lbu", mem_pkg::f3_byte_u, a, 0);
            end
            for (off = 0; off < 3; off++) begin
                a = 32'h0000_0180 + 32'(4 * w + off);
                do_store("half store", mem_pkg::f3_half, a, 32'h0000_8001 ^ 32'(4369 * (w + off)));
                do_load("lh", mem_pkg::f3_half, a, 0);
                do_load("lhu", mem_pkg::f3_half_u, a, 0);
            end
            do_load("byte lanes word view", mem_pkg::f3_word, 32'h0000_0100 + 32'(4 * w), 0);
            do_load("half lanes word view", mem_pkg::f3_word, 32'h0000_0180 + 32'(4 * w), 0);
        end
    endtask

    task automatic test_pass_through();
        int          i;
        logic [31:0] a;
        logic [31:0] rnd;
        for (i = 0; i < 8; i++) begin
            a   = $random(seed);
            rnd = $random(seed);
            issue(1'b0, 1'b0, rnd[2:0], a, 32'd0, rnd[8:4], rnd[9]);
            collect("pass-through", 0);
            check_data("pass-through data", a, res_data);
            check_rd("pass-through rd", rnd[8:4], res_rd);
            check_flag("pass-through reg_wen", rnd[9], res_wen);
            check_flag("pass-through fault", 1'b0, res_fault);
        end
    endtask

    task automatic test_faults();
        expect_fault("load at mem_bytes", 1'b1, 1'b0, mem_pkg::f3_word, 32'h0000_0400);
        expect_fault("store at mem_bytes", 1'b0, 1'b1, mem_pkg::f3_word, 32'h0000_0400);
        expect_fault("store far above", 1'b0, 1'b1, mem_pkg::f3_byte, 32'h8000_0013);
        expect_fault("load far above", 1'b1, 1'b0, mem_pkg::f3_half_u, 32'hffff_fffc);
        expect_fault("lh offset 3", 1'b1, 1'b0, mem_pkg::f3_half, 32'h0000_0013);
        expect_fault("sh offset 3", 1'b0, 1'b1, mem_pkg::f3_half, 32'h0000_0023);
        expect_fault("lw offset 1", 1'b1, 1'b0, mem_pkg::f3_word, 32'h0000_0031);
        expect_fault("sw offset 1", 1'b0, 1'b1, mem_pkg::f3_word, 32'h0000_0041);
        do_load("unchanged after fault", mem_pkg::f3_word, 32'h0000_0000, 0);   // alias of 0x400
        do_load("unchanged after fault", mem_pkg::f3_word, 32'h0000_0010, 0);
        do_load("unchanged after fault", mem_pkg::f3_word, 32'h0000_0020, 0);
        do_load("unchanged after fault", mem_pkg::f3_word, 32'h0000_0024, 0);
        do_load("unchanged after fault", mem_pkg::f3_word, 32'h0000_0040, 0);
    endtask

    task automatic test_back_pressure();
        int          i;
        logic [31:0] a;
        logic [31:0] rnd;
        for (i = 0; i < 6; i++) begin
            rnd = $random(seed);
            a   = {22'd0, rnd[9:2], 2'b00};
            out_ready <= 1'b0;
            do_load("back-pressure load", mem_pkg::f3_word, a, 1 + int'(rnd[12:10]));
        end
        rnd = $random(seed);
        out_ready <= 1'b0;
        issue(1'b0, 1'b0, mem_pkg::f3_word, rnd, 32'd0, 5'd3, 1'b1);
        collect("back-pressure pass-through", 1 + int'(rnd[2:0]));
        check_data("back-pressure pass-through", rnd, res_data);
    endtask

    task automatic test_random();
        int          i;
        logic [31:0] a;
        logic [31:0] rnd;
        logic [2:0]  f3;
        for (i = 0; i < 200; i++) begin
            rnd = $random(seed);
            a   = {22'd0, rnd[9:0]};
            case (rnd[14:12])
                3'd0:    f3 = mem_pkg::f3_byte;
                3'd1:    f3 = mem_pkg::f3_half;
                3'd3:    f3 = mem_pkg::f3_byte_u;
                3'd4:    f3 = mem_pkg::f3_half_u;
                default: f3 = mem_pkg::f3_word;
            endcase
            if (rnd[20]) f3 = {1'b0, f3[1:0]};   // stores have no unsigned forms
            if (access_bytes(f3) == 4) a[1:0] = 2'b00;
            else if (access_bytes(f3) == 2 && a[1:0] == 2'b11) a[1:0] = 2'b10;
            if (rnd[20]) begin
                rnd = $random(seed);
                do_store("random store", f3, a, rnd);
            end else begin
                do_load("random load", f3, a, 0);
            end
        end
    endtask

    initial begin
        reset      <= 1'b1;
        in_valid   <= 1'b0;
        op_load    <= 1'b0;
        op_store   <= 1'b0;
        funct3     <= 3'd0;
        addr       <= 32'd0;
        store_data <= 32'd0;
        rd         <= 5'd0;
        reg_wen    <= 1'b0;
        out_ready  <= 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_flag("after reset in_ready", 1'b1, in_ready);
        check_flag("after reset out_valid", 1'b0, out_valid);
        @(posedge clock);
        test_word_round_trip();
        test_sub_word();
        test_pass_through();
        test_faults();
        test_back_pressure();
        test_random();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
